// ==== Makefile ====
# Verilator build and run of the pattern player testbench

sim:
	verilator --binary --timing -f build.f --top-module tbSeqCore -Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== asymRam.sv ====
// asymmetric dual-port RAM, byte wide port A and a wide port B
// both ports are registered read-first, one byte array holds the contents
`timescale 1ns/100ps
`default_nettype none

module asymRam #(
    parameter int sizeBytes  = 1024,
    parameter int portBWidth = 8
) (
    input  logic                                       clkA,
    // byte port
    input  logic                                       weA,
    input  logic [$clog2(sizeBytes)-1:0]               addrA,
    input  logic [7:0]                                 diA,
    output logic [7:0]                                 doA,
    // word port
    input  logic                                       weB,
    input  logic [$clog2(sizeBytes*8/portBWidth)-1:0]  addrB,
    input  logic [portBWidth-1:0]                      diB,
    output logic [portBWidth-1:0]                      doB
);

    localparam int ratio     = portBWidth / 8;         // bytes per port B word
    localparam int addrABits = $clog2(sizeBytes);

    logic [7:0] mem [0:sizeBytes-1];

    // start from a cleared memory in simulation
    initial begin
        for (int k = 0; k < sizeBytes; k++) begin
            mem[k] = 8'h00;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // both ports share clkA, so one process serves them

    always_ff @(posedge clkA) begin
        if (weA) begin
            mem[addrA] <= diA;
        end
        doA <= mem[addrA];   // old contents, the write lands after this edge

        // a word is split into consecutive bytes, lowest byte at the lowest address
        for (int i = 0; i < ratio; i++) begin
            if (weB) begin
                mem[addrABits'(int'(addrB) * ratio + i)] <= diB[8*i +: 8];
            end
            doB[8*i +: 8] <= mem[addrABits'(int'(addrB) * ratio + i)];
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
seqPkg.sv
asymRam.sv
busRegs.sv
seqEngine.sv
seqCore.sv
tbSeqCore.sv

// ==== busRegs.sv ====
// byte bus decoder for the pattern player
// routes accesses to the control registers or the memory window and
// returns read data one cycle after the read strobe
`timescale 1ns/100ps
`default_nettype none

module busRegs (
    input  logic             clkA,
    input  logic             rstN,
    // host bus
    input  seqPkg::busAddrT  busAddr,
    input  logic             busWr,
    input  logic             busRd,
    input  seqPkg::byteT     busWrData,
    output seqPkg::byteT     busRdData,
    // RAM port A
    output logic             weA,
    output seqPkg::byteAddrT addrA,
    output seqPkg::byteT     diA,
    input  seqPkg::byteT     doA,
    // engine control
    output logic             startPulse,
    output logic             recordEn,
    output seqPkg::wordAddrT startWord,
    output seqPkg::lengthT   runLength,
    input  logic             busy,
    input  logic             done
);

    logic             memSel;
    logic             regWr;
    logic             idle;
    seqPkg::byteAddrT regAddr;
    seqPkg::byteT     statusByte;
    seqPkg::byteT     regValue;
    seqPkg::byteT     regRdData;
    logic             rdFromMem;

    assign memSel  = busAddr[seqPkg::busAddrBits-1];
    assign regAddr = busAddr[seqPkg::byteAddrBits-1:0];
    assign regWr   = busWr && !memSel;
    assign idle    = !busy && !startPulse;   // a start already issued counts as busy

    // the memory window goes straight to port A
    assign weA   = busWr && memSel;
    assign addrA = regAddr;
    assign diA   = busWrData;

    //////////////////////////////////////////////////////////////////////
    // control registers

    always_ff @(posedge clkA) begin
        if (!rstN) begin
            startPulse <= 1'b0;
            recordEn   <= 1'b0;
            startWord  <= '0;
            runLength  <= '0;
        end else begin
            startPulse <= 1'b0;
            if (regWr) begin
                case (regAddr)
                    seqPkg::regCtrl: begin
                        if (idle) begin   // ctrl writes during a run are dropped
                            recordEn   <= busWrData[seqPkg::ctrlRecordBit];
                            startPulse <= busWrData[seqPkg::ctrlStartBit];
                        end
                    end
                    seqPkg::regStart:  startWord <= busWrData[seqPkg::wordAddrBits-1:0];
                    seqPkg::regLength: runLength <= busWrData[seqPkg::lengthBits-1:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read path, registered so both sources share the RAM latency

    always_comb begin
        statusByte                        = '0;
        statusByte[seqPkg::statBusyBit]   = busy;
        statusByte[seqPkg::statRecordBit] = recordEn;
        statusByte[seqPkg::statDoneBit]   = done;
    end

    always_comb begin
        regValue = '0;
        case (regAddr)
            seqPkg::regCtrl:   regValue = statusByte;
            seqPkg::regStart:  regValue[seqPkg::wordAddrBits-1:0] = startWord;
            seqPkg::regLength: regValue[seqPkg::lengthBits-1:0] = runLength;
            default:           regValue = '0;
        endcase
    end

    always_ff @(posedge clkA) begin
        if (!rstN) begin
            rdFromMem <= 1'b0;
        end else if (busRd) begin
            rdFromMem <= memSel;
        end
    end

    always_ff @(posedge clkA) begin
        if (busRd) begin
            regRdData <= regValue;
        end
    end

    assign busRdData = rdFromMem ? doA : regRdData;   // port A data arrives in the same cycle

endmodule

`default_nettype wire

// ==== seqCore.sv ====
// pattern player and recorder top level
// joins the bus register block, the shared RAM and the pattern engine
`timescale 1ns/100ps
`default_nettype none

module seqCore (
    input  logic            clkA,
    input  logic            rstN,
    input  seqPkg::busAddrT busAddr,
    input  logic            busWr,
    input  logic            busRd,
    input  seqPkg::byteT    busWrData,
    output seqPkg::byteT    busRdData,
    input  seqPkg::wordT    seqIn,
    output seqPkg::wordT    seqOut,
    output logic            seqValid
);

    logic             weA;
    seqPkg::byteAddrT addrA;
    seqPkg::byteT     diA;
    seqPkg::byteT     doA;
    logic             weB;
    seqPkg::wordAddrT addrB;
    seqPkg::wordT     diB;
    seqPkg::wordT     doB;
    logic             startPulse;
    logic             recordEn;
    seqPkg::wordAddrT startWord;
    seqPkg::lengthT   runLength;
    logic             busy;
    logic             done;

    busRegs busRegs_i (
        .clkA       (clkA),
        .rstN       (rstN),
        .busAddr    (busAddr),
        .busWr      (busWr),
        .busRd      (busRd),
        .busWrData  (busWrData),
        .busRdData  (busRdData),
        .weA        (weA),
        .addrA      (addrA),
        .diA        (diA),
        .doA        (doA),
        .startPulse (startPulse),
        .recordEn   (recordEn),
        .startWord  (startWord),
        .runLength  (runLength),
        .busy       (busy),
        .done       (done)
    );

    // byte port for the host, word port for the engine
    asymRam #(
        .sizeBytes  (seqPkg::ramBytes),
        .portBWidth (seqPkg::wordWidth)
    ) asymRam_i (
        .clkA  (clkA),
        .weA   (weA),
        .addrA (addrA),
        .diA   (diA),
        .doA   (doA),
        .weB   (weB),
        .addrB (addrB),
        .diB   (diB),
        .doB   (doB)
    );

    seqEngine seqEngine_i (
        .clkA       (clkA),
        .rstN       (rstN),
        .startPulse (startPulse),
        .recordEn   (recordEn),
        .startWord  (startWord),
        .runLength  (runLength),
        .seqIn      (seqIn),
        .weB        (weB),
        .addrB      (addrB),
        .diB        (diB),
        .doB        (doB),
        .seqOut     (seqOut),
        .seqValid   (seqValid),
        .busy       (busy),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== seqEngine.sv ====
// pattern engine, walks port B through a run of words
// plays each word out and optionally records seqIn into the same word
`timescale 1ns/100ps
`default_nettype none

module seqEngine (
    input  logic             clkA,
    input  logic             rstN,
    // control from the register block
    input  logic             startPulse,
    input  logic             recordEn,
    input  seqPkg::wordAddrT startWord,
    input  seqPkg::lengthT   runLength,
    input  seqPkg::wordT     seqIn,
    // RAM port B
    output logic             weB,
    output seqPkg::wordAddrT addrB,
    output seqPkg::wordT     diB,
    input  seqPkg::wordT     doB,
    // pattern output and status
    output seqPkg::wordT     seqOut,
    output logic             seqValid,
    output logic             busy,
    output logic             done
);

    logic             addrPhase;   // high while addrB points at a word of the run
    seqPkg::wordAddrT wordAddr;
    seqPkg::lengthT   remaining;   // words still to be addressed, including the current one

    //////////////////////////////////////////////////////////////////////
    // run state

    always_ff @(posedge clkA) begin
        if (!rstN) begin
            addrPhase <= 1'b0;
            seqValid  <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            seqValid <= addrPhase;   // RAM output follows the address by one cycle
            if (startPulse) begin
                if (runLength == '0) begin
                    done <= 1'b1;   // empty run finishes without touching the RAM
                end else begin
                    busy      <= 1'b1;
                    done      <= 1'b0;
                    addrPhase <= 1'b1;
                end
            end else begin
                if (addrPhase && remaining == seqPkg::lengthT'(1)) begin
                    addrPhase <= 1'b0;
                end
                // last output cycle is ending here
                if (seqValid && !addrPhase) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // address and word counters

    always_ff @(posedge clkA) begin
        if (startPulse) begin
            wordAddr  <= startWord;
            remaining <= runLength;
        end else if (addrPhase) begin
            wordAddr  <= wordAddr + seqPkg::wordAddrT'(1);   // wraps at the end of memory
            remaining <= remaining - seqPkg::lengthT'(1);
        end
    end

    assign addrB  = wordAddr;
    assign weB    = recordEn && addrPhase;   // record into the word being read
    assign diB    = seqIn;
    assign seqOut = doB;                     // read-first, so this is the old word

endmodule

`default_nettype wire

// ==== seqPkg.sv ====
// pattern player package
// bus map, memory geometry, control bit positions and shared vector types
`default_nettype none

package seqPkg;

    localparam int ramBytes     = 256;
    localparam int wordWidth    = 16;
    localparam int wordCount    = ramBytes * 8 / wordWidth;
    localparam int byteAddrBits = $clog2(ramBytes);
    localparam int wordAddrBits = $clog2(wordCount);
    localparam int busAddrBits  = byteAddrBits + 1;   // top bit selects the memory window
    localparam int lengthBits   = 8;

    typedef logic [7:0]              byteT;
    typedef logic [wordWidth-1:0]    wordT;
    typedef logic [byteAddrBits-1:0] byteAddrT;
    typedef logic [wordAddrBits-1:0] wordAddrT;
    typedef logic [busAddrBits-1:0]  busAddrT;
    typedef logic [lengthBits-1:0]   lengthT;

    // register offsets inside the register window
    localparam byteAddrT regCtrl   = byteAddrT'(0);
    localparam byteAddrT regStart  = byteAddrT'(1);
    localparam byteAddrT regLength = byteAddrT'(2);

    localparam int ctrlStartBit  = 0;   // write side of regCtrl
    localparam int ctrlRecordBit = 1;
    localparam int statBusyBit   = 0;   // read side of regCtrl
    localparam int statRecordBit = 1;
    localparam int statDoneBit   = 2;

endpackage

`default_nettype wire

// ==== tbSeqCore.sv ====
// testbench for the pattern player top level
// LFSR driven bus traffic and runs, checked against a byte model of the memory
`timescale 1ns/100ps
`default_nettype none

module tbSeqCore;

    localparam int wordBytes = seqPkg::wordWidth / 8;

    logic            clkA = 1'b0;
    logic            rstN;
    seqPkg::busAddrT busAddr;
    logic            busWr;
    logic            busRd;
    seqPkg::byteT    busWrData;
    seqPkg::byteT    busRdData;
    seqPkg::wordT    seqIn;
    seqPkg::wordT    seqOut;
    logic            seqValid;

    logic [31:0]  lfsrState = 32'h25d4_471f;
    seqPkg::byteT model [0:seqPkg::ramBytes-1];   // expected memory contents
    int           errorCount = 0;
    int           testCount = 0;

    seqCore seqCore_i (.*);

    always #20 clkA = ~clkA;

    //////////////////////////////////////////////////////////////////////
    // helpers

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b         = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            v         = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic seqPkg::busAddrT memAddr(input int i);
        return {1'b1, seqPkg::byteAddrT'(i)};
    endfunction

    function automatic seqPkg::busAddrT regAddr(input seqPkg::byteAddrT r);
        return {1'b0, r};
    endfunction

    // lower byte address holds the lower bits of a word
    function automatic seqPkg::wordT modelWord(input int w);
        seqPkg::wordT v;
        for (int j = 0; j < wordBytes; j++) begin
            v[8*j +: 8] = model[w * wordBytes + j];
        end
        return v;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    // bus tasks start and end 2 ns after a rising edge
    task automatic writeByte(input seqPkg::busAddrT addr, input seqPkg::byteT data);
        busAddr   = addr;
        busWrData = data;
        busWr     = 1'b1;
        @(posedge clkA);
        #2;
        busWr = 1'b0;
    endtask

    task automatic readByte(input seqPkg::busAddrT addr, output seqPkg::byteT data);
        busAddr = addr;
        busRd   = 1'b1;
        @(posedge clkA);
        #2;
        busRd = 1'b0;
        data  = busRdData;   // valid in the cycle after the sampling edge
    endtask

    task automatic checkMemory();
        seqPkg::byteT d;
        for (int i = 0; i < seqPkg::ramBytes; i++) begin
            readByte(memAddr(i), d);
            checkValue($sformatf("busRdData[byte %0d]", i), 32'(d), 32'(model[i]));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one run, with an optional second start while busy

    task automatic runPattern(input int startW, input int len, input bit rec, input bit extraStart);
        seqPkg::wordT recorded [$];
        seqPkg::wordT heldIn;
        seqPkg::byteT status;
        int           count;
        int           idx;
        int           polls;
        bit           sawValid;
        count    = 0;
        sawValid = 1'b0;
        writeByte(regAddr(seqPkg::regStart), seqPkg::byteT'(startW));
        writeByte(regAddr(seqPkg::regLength), seqPkg::byteT'(len));
        seqIn = seqPkg::wordT'(randBits(seqPkg::wordWidth));
        writeByte(regAddr(seqPkg::regCtrl), {6'b0, rec, 1'b1});
        for (int cyc = 0; cyc < len + 8; cyc++) begin
            @(posedge clkA);
            heldIn = seqIn;   // the value the engine records at this edge
            #1;
            if (seqValid) begin
                idx = (startW + count) % seqPkg::wordCount;
                checkValue($sformatf("seqOut[word %0d]", idx), 32'(seqOut), 32'(modelWord(idx)));
                recorded.push_back(heldIn);
                count++;
                sawValid = 1'b1;
            end
            #1;
            seqIn = seqPkg::wordT'(randBits(seqPkg::wordWidth));
            busWr = extraStart && (cyc == 1);   // lands on an edge while busy is high
            if (sawValid && !seqValid) break;
        end
        busWr = 1'b0;
        checkValue("seqValid count", 32'(count), 32'(len));
        if (rec) begin
            foreach (recorded[k]) begin
                idx = (startW + k) % seqPkg::wordCount;
                for (int j = 0; j < wordBytes; j++) begin
                    model[idx * wordBytes + j] = recorded[k][8*j +: 8];
                end
            end
        end
        polls  = 0;
        status = '0;
        while (!status[seqPkg::statDoneBit] && polls < 20) begin
            readByte(regAddr(seqPkg::regCtrl), status);
            polls++;
        end
        if (!status[seqPkg::statDoneBit]) begin
            $display("timeout at %0t ns: the run never reported done", $time);
            errorCount++;
        end
        checkValue("busRdData[ctrl]", 32'(status), 32'({5'b0, 1'b1, rec, 1'b0}));
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        seqPkg::byteT d;
        seqPkg::byteT v;
        seqPkg::byteT w;
        int           errs;
        int           a;
        rstN      = 1'b0;
        busAddr   = '0;
        busWr     = 1'b0;
        busRd     = 1'b0;
        busWrData = '0;
        seqIn     = '0;
        for (int i = 0; i < seqPkg::ramBytes; i++) model[i] = 8'h00;
        repeat (5) @(posedge clkA);
        #2;
        rstN = 1'b1;

        errs = errorCount;
        readByte(regAddr(seqPkg::regCtrl), d);
        checkValue("busRdData[ctrl]", 32'(d), 32'h0);
        for (int i = 0; i < 8; i++) begin
            @(posedge clkA);
            #2;
            checkValue("seqValid", 32'(seqValid), 32'h0);
        end
        finishTest("reset state", errs);

        errs = errorCount;
        for (int i = 0; i < seqPkg::ramBytes; i++) begin
            model[i] = seqPkg::byteT'(randBits(8));
            writeByte(memAddr(i), model[i]);
        end
        for (int i = 0; i < 48; i++) begin
            a = int'(randBits(seqPkg::byteAddrBits));
            readByte(memAddr(a), d);
            checkValue($sformatf("busRdData[byte %0d]", a), 32'(d), 32'(model[a]));
        end
        finishTest("memory window", errs);

        errs = errorCount;
        v = seqPkg::byteT'(randBits(8));
        w = seqPkg::byteT'(randBits(8));
        writeByte(regAddr(seqPkg::regStart), v);
        writeByte(regAddr(seqPkg::regLength), w);
        readByte(regAddr(seqPkg::regStart), d);
        checkValue("busRdData[start]", 32'(d), 32'({1'b0, v[6:0]}));   // start is 7 bits
        readByte(regAddr(seqPkg::regLength), d);
        checkValue("busRdData[length]", 32'(d), 32'(w));
        finishTest("registers", errs);

        // no run has finished yet, so done can only come from this empty run
        errs = errorCount;
        runPattern(int'(randBits(7)), 0, 1'b0, 1'b0);
        finishTest("empty run", errs);

        errs = errorCount;
        runPattern(int'(randBits(7)), 1 + int'(randBits(5)), 1'b0, 1'b0);
        checkMemory();
        finishTest("play run", errs);

        errs = errorCount;
        runPattern(int'(randBits(7)), 20 + int'(randBits(6)), 1'b1, 1'b0);
        checkMemory();
        finishTest("record run", errs);

        errs = errorCount;
        runPattern(int'(randBits(7)), 6, 1'b0, 1'b1);
        finishTest("start while busy", errs);

        $display("%0d tests, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
